// File: src/core_pkg.sv
/*
  shared widths, bridge address map and encodings for the core
  everything runs in the single core clock domain
  eol command view keeps the top 7 bits zero, slot lands in bits 16..13
*/
package core_pkg;

  // bus widths
  localparam int DATA_W          = 32;
  localparam int ADDR_W          = 32;
  localparam int INTERACT_ADDR_W = 6;
  localparam int SLOT_W          = 4;

  ////////////////////////////////////////
  // bridge address map

  localparam logic [ADDR_W-1:0] SETTINGS_BASE = 32'h1000_0000;
  localparam int MENU_RESET_OFFSET  = 0;
  localparam int RESET_PLUS_OFFSET  = 4;
  localparam int SCALER_SLOT_OFFSET = 8;

  // 256 byte window, word index from addr[7:2]
  localparam logic [ADDR_W-1:0] INTERACT_BASE = 32'h1000_0100;

  ////////////////////////////////////////
  // data-slot request codes

  localparam logic [1:0] REQ_READ     = 2'd0;
  localparam logic [1:0] REQ_WRITE    = 2'd1;
  localparam logic [1:0] REQ_GETFILE  = 2'd2;
  localparam logic [1:0] REQ_OPENFILE = 2'd3;

  ////////////////////////////////////////
  // video output word

  // either a pixel colour or the scaler end-of-line command
  typedef union packed {
    struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
    } colour;
    struct packed {
      logic [6:0]        zero_hi;
      logic [SLOT_W-1:0] slot;
      logic [12:0]       zero_lo;
    } eol;
  } pixel_word_u;

endpackage

// File: src/csr_if.sv
/*
  word access port into the interact register file
  rd in cycle N returns rdata in cycle N+1
*/
`timescale 1ns/10ps

interface csr_if import core_pkg::*; ();

  logic                       wr;
  logic                       rd;
  logic [INTERACT_ADDR_W-1:0] addr;
  logic [DATA_W-1:0]          wdata;
  logic [DATA_W-1:0]          rdata;

  modport host (output wr, rd, addr, wdata, input rdata);
  modport regs (input wr, rd, addr, wdata, output rdata);

endinterface

// File: src/bridge_decoder.sv
/*
  bridge bus decode for the settings registers and the interact window
  read data follows bridge_rd by exactly one cycle
  menu reset register is write only and reads back 0
*/
`timescale 1ns/10ps

module bridge_decoder
  import core_pkg::*;
(
  input  logic              clk_sys_57_12,
  input  logic              reset,
  input  logic [ADDR_W-1:0] bridge_addr,
  input  logic              bridge_wr,
  input  logic              bridge_rd,
  input  logic [DATA_W-1:0] bridge_wr_data,
  output logic [DATA_W-1:0] bridge_rd_data,
  output logic              bridge_rd_valid,
  output logic              menu_reset,
  output logic              reset_plus_en,
  output logic [SLOT_W-1:0] scaler_slot,
  csr_if.host               csr
);

  localparam logic [ADDR_W-1:0] MENU_ADDR   = SETTINGS_BASE + MENU_RESET_OFFSET;
  localparam logic [ADDR_W-1:0] PLUS_ADDR   = SETTINGS_BASE + RESET_PLUS_OFFSET;
  localparam logic [ADDR_W-1:0] SCALER_ADDR = SETTINGS_BASE + SCALER_SLOT_OFFSET;

  logic              interact_hit;
  logic              interact_sel;
  logic [DATA_W-1:0] settings_rdata;

  assign interact_hit = bridge_addr[ADDR_W-1:8] == INTERACT_BASE[ADDR_W-1:8];

  // interact accesses go straight through
  assign csr.wr    = bridge_wr && interact_hit;
  assign csr.rd    = bridge_rd && interact_hit;
  assign csr.addr  = bridge_addr[INTERACT_ADDR_W+1:2];
  assign csr.wdata = bridge_wr_data;

  // single cycle, same as the write strobe
  assign menu_reset = bridge_wr && bridge_addr == MENU_ADDR;

  ////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      reset_plus_en   <= 1'b0;
      scaler_slot     <= '0;
      bridge_rd_valid <= 1'b0;
    end else begin
      bridge_rd_valid <= bridge_rd;
      if (bridge_wr && bridge_addr == PLUS_ADDR) begin
        reset_plus_en <= bridge_wr_data[0];
      end
      if (bridge_wr && bridge_addr == SCALER_ADDR) begin
        scaler_slot <= bridge_wr_data[SLOT_W-1:0];
      end
    end
  end

  // read select lines up with the file's registered rdata
  always_ff @(posedge clk_sys_57_12) begin
    interact_sel   <= interact_hit;
    settings_rdata <= '0;
    if (bridge_addr == PLUS_ADDR) begin
      settings_rdata <= {{(DATA_W-1){1'b0}}, reset_plus_en};
    end else if (bridge_addr == SCALER_ADDR) begin
      settings_rdata <= {{(DATA_W-SLOT_W){1'b0}}, scaler_slot};
    end
  end

  assign bridge_rd_data = interact_sel ? csr.rdata : settings_rdata;

endmodule

// File: src/interact_regs.sv
/*
  64 x 32 interact register file, no reset on contents
  a same cycle read returns the old word
*/
`timescale 1ns/10ps

module interact_regs
  import core_pkg::*;
(
  input logic clk_sys_57_12,
  csr_if.regs csr
);

  localparam int DEPTH = 1 << INTERACT_ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk_sys_57_12) begin
    if (csr.wr) begin
      mem[csr.addr] <= csr.wdata;
    end
    // registered read, one cycle behind rd
    if (csr.rd) begin
      csr.rdata <= mem[csr.addr];
    end
  end

endmodule

// File: src/reset_sequencer.sv
/*
  core reset hold timer, started by menu write or start button
  button is asynchronous, so 3-4 cycles of latency before the hold starts
  a new start while holding restarts the count
*/
`timescale 1ns/10ps

module reset_sequencer #(
  parameter int RESET_HOLD = 65535
) (
  input  logic clk_sys_57_12,
  input  logic reset,
  input  logic menu_reset,
  input  logic reset_plus_en,
  input  logic start_button,
  output logic core_reset
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [2:0]        button_sync;
  logic              button_prev;
  logic              button_rise;
  logic [HOLD_W-1:0] hold_count;

  // button only counts with enable-plus set
  assign button_rise = button_sync[2] && !button_prev && reset_plus_en;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      button_sync <= '0;
      button_prev <= 1'b0;
      hold_count  <= '0;
    end else begin
      button_sync <= {button_sync[1:0], start_button};
      button_prev <= button_sync[2];
      if (menu_reset || button_rise) begin
        hold_count <= HOLD_W'(RESET_HOLD);
      end else if (hold_count != '0) begin
        hold_count <= hold_count - 1'b1;
      end
    end
  end

  assign core_reset = reset || hold_count != '0;

endmodule

// File: src/rtc_seconds.sv
/*
  seconds counter, loaded from the rtc epoch on a rising rtc_valid
  counts from 0 after reset until the first epoch arrives
*/
`timescale 1ns/10ps

module rtc_seconds
  import core_pkg::*;
#(
  parameter int TICKS_PER_SECOND = 57_120_000
) (
  input  logic              clk_sys_57_12,
  input  logic              reset,
  input  logic              rtc_valid,
  input  logic [DATA_W-1:0] rtc_epoch,
  output logic [DATA_W-1:0] rtc_seconds
);

  localparam int TICK_W = $clog2(TICKS_PER_SECOND);

  logic              valid_prev;
  logic [TICK_W-1:0] tick_count;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      valid_prev  <= 1'b0;
      tick_count  <= '0;
      rtc_seconds <= '0;
    end else begin
      valid_prev <= rtc_valid;
      if (rtc_valid && !valid_prev) begin
        // fresh epoch restarts the second
        rtc_seconds <= rtc_epoch;
        tick_count  <= '0;
      end else if (tick_count == TICK_W'(TICKS_PER_SECOND - 1)) begin
        rtc_seconds <= rtc_seconds + 1'b1;
        tick_count  <= '0;
      end else begin
        tick_count <= tick_count + 1'b1;
      end
    end
  end

endmodule

// File: src/dataslot_request.sv
/*
  turns four data-slot request levels into one valid/ready request
  read > write > getfile > openfile when edges coincide
  edges that arrive while a request is pending are dropped
*/
`timescale 1ns/10ps

module dataslot_request
  import core_pkg::*;
(
  input  logic       clk_sys_57_12,
  input  logic       reset,
  input  logic       slot_read,
  input  logic       slot_write,
  input  logic       slot_getfile,
  input  logic       slot_openfile,
  input  logic       request_ready,
  output logic       request_valid,
  output logic [1:0] request_kind
);

  logic [3:0] level;
  logic [3:0] level_prev;
  logic [3:0] rise;

  // bit order matches the request codes
  assign level = {slot_openfile, slot_getfile, slot_write, slot_read};
  assign rise  = level & ~level_prev;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      level_prev    <= '0;
      request_valid <= 1'b0;
    end else begin
      level_prev <= level;
      if (request_valid) begin
        if (request_ready) begin
          request_valid <= 1'b0;
        end
      end else if (rise != '0) begin
        request_valid <= 1'b1;
      end
    end
  end

  // kind only changes while idle, so it stays stable until accepted
  always_ff @(posedge clk_sys_57_12) begin
    if (!request_valid) begin
      if (rise[0]) begin
        request_kind <= REQ_READ;
      end else if (rise[1]) begin
        request_kind <= REQ_WRITE;
      end else if (rise[2]) begin
        request_kind <= REQ_GETFILE;
      end else if (rise[3]) begin
        request_kind <= REQ_OPENFILE;
      end
    end
  end

endmodule

// File: src/video_formatter.sv
/*
  rgb565 to rgb888 output formatter for the scaler
  slot bit 3 set: colour passes through in the same cycle
  otherwise colour is one cycle late, with black bars and an eol command
  sync outputs are always one cycle late
*/
`timescale 1ns/10ps

module video_formatter
  import core_pkg::*;
(
  input  logic              clk_sys_57_12,
  input  logic              reset,
  input  logic [15:0]       rgb565,
  input  logic              de,
  input  logic              hsync,
  input  logic              vsync,
  input  logic [SLOT_W-1:0] scaler_slot,
  output pixel_word_u       video_rgb,
  output logic              video_de,
  output logic              video_hs,
  output logic              video_vs
);

  logic        pass_through;
  pixel_word_u colour_now;
  pixel_word_u colour_delay;
  logic        de_d1;
  logic        de_d2;

  assign pass_through = scaler_slot[SLOT_W-1];

  // repeat top bits into the new low bits so full scale stays full scale
  always_comb begin
    colour_now          = '0;
    colour_now.colour.r = {rgb565[15:11], rgb565[15:13]};
    colour_now.colour.g = {rgb565[10:5], rgb565[10:9]};
    colour_now.colour.b = {rgb565[4:0], rgb565[4:2]};
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      de_d1    <= 1'b0;
      de_d2    <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      de_d1    <= de;
      de_d2    <= de_d1;
      video_hs <= hsync;
      video_vs <= vsync;
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    colour_delay <= colour_now;
  end

  ////////////////////////////////////////
  // output word select

  // de stretched by one cycle each side in delayed mode
  assign video_de = de || (!pass_through && de_d2);

  always_comb begin
    video_rgb = '0;
    if (pass_through) begin
      if (de) begin
        video_rgb = colour_now;
      end
    end else if (de_d1) begin
      video_rgb = colour_delay;
    end else if (de_d2) begin
      // first cycle after the line
      video_rgb.eol.slot = scaler_slot;
    end
  end

endmodule

// File: src/core_top.sv
/*
  core top level, everything on clk_sys_57_12
  bridge is assumed synchronous to the core clock
  only start_button is treated as asynchronous
*/
`timescale 1ns/10ps

module core_top
  import core_pkg::*;
#(
  parameter int TICKS_PER_SECOND = 57_120_000,
  parameter int RESET_HOLD       = 65535
) (
  input  logic              clk_sys_57_12,
  input  logic              reset,
  // bridge bus
  input  logic [ADDR_W-1:0] bridge_addr,
  input  logic              bridge_wr,
  input  logic              bridge_rd,
  input  logic [DATA_W-1:0] bridge_wr_data,
  output logic [DATA_W-1:0] bridge_rd_data,
  output logic              bridge_rd_valid,
  // reset control
  input  logic              start_button,
  output logic              core_reset,
  // real-time clock
  input  logic              rtc_valid,
  input  logic [DATA_W-1:0] rtc_epoch,
  output logic [DATA_W-1:0] rtc_seconds,
  // data-slot requests
  input  logic              slot_read,
  input  logic              slot_write,
  input  logic              slot_getfile,
  input  logic              slot_openfile,
  output logic              request_valid,
  output logic [1:0]        request_kind,
  input  logic              request_ready,
  // video
  input  logic [15:0]       rgb565,
  input  logic              de,
  input  logic              hsync,
  input  logic              vsync,
  output pixel_word_u       video_rgb,
  output logic              video_de,
  output logic              video_hs,
  output logic              video_vs
);

  logic              menu_reset;
  logic              reset_plus_en;
  logic [SLOT_W-1:0] scaler_slot;

  csr_if csr ();

  ////////////////////////////////////////
  // bridge side

  bridge_decoder i_bridge_decoder (
    .clk_sys_57_12  (clk_sys_57_12),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_rd      (bridge_rd),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .bridge_rd_valid(bridge_rd_valid),
    .menu_reset     (menu_reset),
    .reset_plus_en  (reset_plus_en),
    .scaler_slot    (scaler_slot),
    .csr            (csr.host)
  );

  interact_regs i_interact_regs (
    .clk_sys_57_12(clk_sys_57_12),
    .csr          (csr.regs)
  );

  ////////////////////////////////////////
  // core services

  reset_sequencer #(
    .RESET_HOLD(RESET_HOLD)
  ) i_reset_sequencer (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .menu_reset   (menu_reset),
    .reset_plus_en(reset_plus_en),
    .start_button (start_button),
    .core_reset   (core_reset)
  );

  rtc_seconds #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND)
  ) i_rtc_seconds (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .rtc_valid    (rtc_valid),
    .rtc_epoch    (rtc_epoch),
    .rtc_seconds  (rtc_seconds)
  );

  dataslot_request i_dataslot_request (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .slot_read    (slot_read),
    .slot_write   (slot_write),
    .slot_getfile (slot_getfile),
    .slot_openfile(slot_openfile),
    .request_ready(request_ready),
    .request_valid(request_valid),
    .request_kind (request_kind)
  );

  video_formatter i_video_formatter (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .rgb565       (rgb565),
    .de           (de),
    .hsync        (hsync),
    .vsync        (vsync),
    .scaler_slot  (scaler_slot),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs)
  );

endmodule

// File: verif/tb_core_top.sv
/*
  testbench for core_top with one clock
  inputs driven on the falling edge
  runs with TICKS_PER_SECOND 8 and RESET_HOLD 12 to keep the run short
  video outputs are compared on every rising edge while a video test runs
*/
`timescale 1ns/10ps

module tb_core_top
  import core_pkg::*;
();

  localparam int TICKS      = 8;
  localparam int HOLD       = 12;
  localparam int WAIT_LIMIT = 40;

  localparam logic [ADDR_W-1:0] MENU_ADDR   = SETTINGS_BASE + 32'(MENU_RESET_OFFSET);
  localparam logic [ADDR_W-1:0] PLUS_ADDR   = SETTINGS_BASE + 32'(RESET_PLUS_OFFSET);
  localparam logic [ADDR_W-1:0] SCALER_ADDR = SETTINGS_BASE + 32'(SCALER_SLOT_OFFSET);

  logic              clk_sys_57_12;
  logic              reset;
  logic [ADDR_W-1:0] bridge_addr;
  logic              bridge_wr;
  logic              bridge_rd;
  logic [DATA_W-1:0] bridge_wr_data;
  logic [DATA_W-1:0] bridge_rd_data;
  logic              bridge_rd_valid;
  logic              start_button;
  logic              core_reset;
  logic              rtc_valid;
  logic [DATA_W-1:0] rtc_epoch;
  logic [DATA_W-1:0] rtc_seconds;
  logic              slot_read;
  logic              slot_write;
  logic              slot_getfile;
  logic              slot_openfile;
  logic              request_valid;
  logic [1:0]        request_kind;
  logic              request_ready;
  logic [15:0]       rgb565;
  logic              de;
  logic              hsync;
  logic              vsync;
  pixel_word_u       video_rgb;
  logic              video_de;
  logic              video_hs;
  logic              video_vs;

  // reference model state
  logic [DATA_W-1:0] shadow [64];
  logic              model_plus;
  logic [SLOT_W-1:0] model_slot;
  logic [31:0]       lcg_state;

  // input history for the video compare
  logic              video_check_en;
  logic              de_h1;
  logic              de_h2;
  logic              hs_h1;
  logic              vs_h1;
  logic [15:0]       rgb_h1;

  int n_checks;
  int n_errors;
  int n_tests;
  int n_tests_failed;
  int errors_at_start;

  core_top #(
    .TICKS_PER_SECOND(TICKS),
    .RESET_HOLD      (HOLD)
  ) i_dut (
    .clk_sys_57_12  (clk_sys_57_12),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_rd      (bridge_rd),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .bridge_rd_valid(bridge_rd_valid),
    .start_button   (start_button),
    .core_reset     (core_reset),
    .rtc_valid      (rtc_valid),
    .rtc_epoch      (rtc_epoch),
    .rtc_seconds    (rtc_seconds),
    .slot_read      (slot_read),
    .slot_write     (slot_write),
    .slot_getfile   (slot_getfile),
    .slot_openfile  (slot_openfile),
    .request_valid  (request_valid),
    .request_kind   (request_kind),
    .request_ready  (request_ready),
    .rgb565         (rgb565),
    .de             (de),
    .hsync          (hsync),
    .vsync          (vsync),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  always #20 clk_sys_57_12 = ~clk_sys_57_12;

  ////////////////////////////////////////
  // reference functions

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1:8] == INTERACT_BASE[ADDR_W-1:8]) begin
      return shadow[addr[7:2]];
    end
    if (addr == PLUS_ADDR) begin
      return {31'b0, model_plus};
    end
    if (addr == SCALER_ADDR) begin
      return {28'b0, model_slot};
    end
    return '0;
  endfunction

  // priority read over write over getfile over openfile
  // rise bits as {open, get, write, read}
  function automatic logic [1:0] expected_kind(input logic [3:0] rise);
    if (rise[0]) begin
      return REQ_READ;
    end
    if (rise[1]) begin
      return REQ_WRITE;
    end
    if (rise[2]) begin
      return REQ_GETFILE;
    end
    return REQ_OPENFILE;
  endfunction

  function automatic logic [DATA_W-1:0] expected_seconds(input logic [DATA_W-1:0] epoch,
                                                         input int cycles);
    return epoch + 32'(cycles / TICKS);
  endfunction

  // 5 or 6 bits scaled so that full scale maps to 255
  function automatic pixel_word_u expand_rgb565(input logic [15:0] p);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = 8'(p[15:11]) * 8'd8 + 8'(p[15:11]) / 8'd4;
    g = 8'(p[10:5]) * 8'd4 + 8'(p[10:5]) / 8'd16;
    b = 8'(p[4:0]) * 8'd8 + 8'(p[4:0]) / 8'd4;
    return {r, g, b};
  endfunction

  function automatic pixel_word_u expected_pixel(input logic pass, input logic de_now,
      input logic de_1, input logic de_2, input logic [15:0] rgb_now,
      input logic [15:0] rgb_1, input logic [SLOT_W-1:0] slot);
    pixel_word_u w;
    w = '0;
    if (pass) begin
      if (de_now) begin
        w = expand_rgb565(rgb_now);
      end
    end else if (de_1) begin
      w = expand_rgb565(rgb_1);
    end else if (de_2) begin
      // end-of-line command with the slot in bits 16..13
      w = 24'(slot) << 13;
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // compare tasks

  task automatic log_failure(input string msg);
    n_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_pixel(input string name, input pixel_word_u got,
                             input pixel_word_u exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_kind(input string name, input logic [1:0] got, input logic [1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // video compare sampled before the edge updates the DUT
  always @(posedge clk_sys_57_12) begin
    if (video_check_en) begin
      check_pixel("video_rgb", video_rgb,
                  expected_pixel(model_slot[SLOT_W-1], de, de_h1, de_h2, rgb565, rgb_h1,
                                 model_slot));
      check_bit("video_de", video_de, model_slot[SLOT_W-1] ? de : (de || de_h2));
      check_bit("video_hs", video_hs, hs_h1);
      check_bit("video_vs", video_vs, vs_h1);
    end
    de_h2  = de_h1;
    de_h1  = de;
    rgb_h1 = rgb565;
    hs_h1  = hsync;
    vs_h1  = vsync;
  end

  ////////////////////////////////////////
  // bus and wait helpers

  task automatic begin_test();
    errors_at_start = n_errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (n_errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      n_tests_failed++;
      $display("test %s: FAILED with %0d errors", name, n_errors - errors_at_start);
    end
  endtask

  task automatic bridge_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_sys_57_12);
    bridge_wr = 1'b0;
    if (addr[ADDR_W-1:8] == INTERACT_BASE[ADDR_W-1:8]) begin
      shadow[addr[7:2]] = data;
    end else if (addr == PLUS_ADDR) begin
      model_plus = data[0];
    end else if (addr == SCALER_ADDR) begin
      model_slot = data[SLOT_W-1:0];
    end
  endtask

  // data and valid show up exactly one cycle after the read strobe
  task automatic bridge_read(input logic [ADDR_W-1:0] addr);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(negedge clk_sys_57_12);
    bridge_rd = 1'b0;
    check_bit("bridge_rd_valid", bridge_rd_valid, 1'b1);
    check_word("bridge_rd_data", bridge_rd_data, expected_read(addr));
    @(negedge clk_sys_57_12);
    check_bit("bridge_rd_valid", bridge_rd_valid, 1'b0);
  endtask

  task automatic measure_reset_pulse(output int len);
    len = 0;
    while (core_reset && len < WAIT_LIMIT) begin
      @(negedge clk_sys_57_12);
      len++;
    end
    if (len >= WAIT_LIMIT) begin
      log_failure("core_reset did not fall again");
    end
  endtask

  task automatic wait_reset_rise(output int lat);
    lat = 0;
    while (!core_reset && lat < WAIT_LIMIT) begin
      @(negedge clk_sys_57_12);
      lat++;
    end
    if (!core_reset) begin
      log_failure("core_reset never went high after the button press");
    end
  endtask

  task automatic wait_request(output int lat);
    lat = 0;
    while (!request_valid && lat < WAIT_LIMIT) begin
      @(negedge clk_sys_57_12);
      lat++;
    end
    if (!request_valid) begin
      log_failure("request_valid never went high");
    end
  endtask

  task automatic drive_levels(input logic [3:0] levels);
    {slot_openfile, slot_getfile, slot_write, slot_read} = levels;
  endtask

  task automatic drive_line(input int active, input int blank);
    logic [31:0] word;
    int          i;
    for (i = 0; i < active + blank; i++) begin
      word   = lcg_next();
      rgb565 = word[15:0];
      de     = i < active;
      hsync  = i == active + 1;
      vsync  = word[16];
      @(negedge clk_sys_57_12);
    end
  endtask

  task automatic run_lines(input int lines);
    int n;
    repeat (2) @(negedge clk_sys_57_12);
    video_check_en = 1'b1;
    for (n = 0; n < lines; n++) begin
      drive_line(4 + int'(lcg_next() % 32'd8), 3 + int'(lcg_next() % 32'd4));
    end
    video_check_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // tests

  task automatic test_reset_state();
    begin_test();
    check_bit("bridge_rd_valid", bridge_rd_valid, 1'b0);
    check_bit("request_valid", request_valid, 1'b0);
    check_bit("core_reset", core_reset, 1'b0);
    check_bit("video_de", video_de, 1'b0);
    check_word("rtc_seconds", rtc_seconds, '0);
    end_test("reset state");
  endtask

  task automatic test_interact();
    int order [64];
    int i;
    int j;
    int tmp;
    begin_test();
    for (i = 0; i < 64; i++) begin
      bridge_write(INTERACT_BASE + 32'(4 * i), lcg_next());
      order[i] = i;
    end
    // overwrite some words so reads must see the latest write
    for (i = 0; i < 16; i++) begin
      j = int'(lcg_next() % 32'd64);
      bridge_write(INTERACT_BASE + 32'(4 * j), lcg_next());
    end
    for (i = 63; i > 0; i--) begin
      j        = int'(lcg_next() % 32'(i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < 64; i++) begin
      bridge_read(INTERACT_BASE + 32'(4 * order[i]));
    end
    end_test("interact register file");
  endtask

  task automatic test_settings();
    begin_test();
    bridge_write(SCALER_ADDR, lcg_next());
    bridge_write(PLUS_ADDR, 32'h1);
    bridge_read(SCALER_ADDR);
    bridge_read(PLUS_ADDR);
    bridge_read(MENU_ADDR);
    bridge_read(SETTINGS_BASE + 32'hC);
    bridge_read(32'h2000_0100);
    end_test("settings registers");
  endtask

  task automatic test_reset_sequencer();
    int len;
    int lat;
    begin_test();
    bridge_write(MENU_ADDR, 32'h1);
    measure_reset_pulse(len);
    check_word("core_reset length", 32'(len), 32'(HOLD));
    // second start part way through restarts the hold
    bridge_write(MENU_ADDR, 32'h1);
    repeat (4) @(negedge clk_sys_57_12);
    bridge_write(MENU_ADDR, 32'h1);
    measure_reset_pulse(len);
    check_word("core_reset length after restart", 32'(len), 32'(HOLD));
    bridge_write(PLUS_ADDR, 32'h0);
    start_button = 1'b1;
    repeat (8) begin
      @(negedge clk_sys_57_12);
      check_bit("core_reset", core_reset, 1'b0);
    end
    start_button = 1'b0;
    repeat (4) @(negedge clk_sys_57_12);
    bridge_write(PLUS_ADDR, 32'h1);
    start_button = 1'b1;
    wait_reset_rise(lat);
    if (lat < 3 || lat > 5) begin
      log_failure($sformatf("core_reset started %0d cycles after the button", lat));
    end
    start_button = 1'b0;
    measure_reset_pulse(len);
    check_word("core_reset length from button", 32'(len), 32'(HOLD));
    end_test("reset sequencer");
  endtask

  task automatic test_rtc();
    logic [DATA_W-1:0] epoch;
    int                c;
    begin_test();
    epoch     = lcg_next();
    rtc_epoch = epoch;
    rtc_valid = 1'b1;
    @(negedge clk_sys_57_12);
    check_word("rtc_seconds", rtc_seconds, epoch);
    // every cycle, so an early or a late tick shows up
    for (c = 1; c <= 3 * TICKS; c++) begin
      @(negedge clk_sys_57_12);
      check_word("rtc_seconds", rtc_seconds, expected_seconds(epoch, c));
    end
    // reload part way through a second
    rtc_valid = 1'b0;
    repeat (3) @(negedge clk_sys_57_12);
    epoch     = lcg_next();
    rtc_epoch = epoch;
    rtc_valid = 1'b1;
    @(negedge clk_sys_57_12);
    check_word("rtc_seconds after reload", rtc_seconds, epoch);
    for (c = 1; c <= TICKS; c++) begin
      @(negedge clk_sys_57_12);
      check_word("rtc_seconds after reload", rtc_seconds, expected_seconds(epoch, c));
    end
    rtc_valid = 1'b0;
    end_test("rtc seconds");
  endtask

  task automatic test_requests();
    logic [31:0] word;
    int          lat;
    int          n;
    begin_test();
    request_ready = 1'b0;
    drive_levels(4'b1010);
    wait_request(lat);
    check_word("request latency", 32'(lat), 32'd1);
    check_kind("request_kind", request_kind, expected_kind(4'b1010));
    // read edge while waiting must be dropped
    drive_levels(4'b1011);
    repeat (3) begin
      @(negedge clk_sys_57_12);
      check_bit("request_valid", request_valid, 1'b1);
      check_kind("request_kind", request_kind, expected_kind(4'b1010));
    end
    request_ready = 1'b1;
    @(negedge clk_sys_57_12);
    request_ready = 1'b0;
    repeat (3) begin
      check_bit("request_valid", request_valid, 1'b0);
      @(negedge clk_sys_57_12);
    end
    drive_levels(4'b0000);
    @(negedge clk_sys_57_12);
    for (n = 0; n < 8; n++) begin
      word = lcg_next();
      if (word[3:0] == 4'b0000) begin
        word[2] = 1'b1;
      end
      drive_levels(word[3:0]);
      request_ready = 1'b1;
      wait_request(lat);
      check_kind("request_kind", request_kind, expected_kind(word[3:0]));
      @(negedge clk_sys_57_12);
      check_bit("request_valid", request_valid, 1'b0);
      drive_levels(4'b0000);
      request_ready = 1'b0;
      @(negedge clk_sys_57_12);
    end
    end_test("data-slot requests");
  endtask

  task automatic test_video();
    logic [31:0] word;
    begin_test();
    word = lcg_next();
    bridge_write(SCALER_ADDR, {28'b0, 1'b1, word[2:0]});
    run_lines(4);
    word = lcg_next();
    bridge_write(SCALER_ADDR, {28'b0, 1'b0, word[2:0]});
    run_lines(4);
    end_test("video formatter");
  endtask

  initial begin
    clk_sys_57_12  = 1'b0;
    lcg_state      = 32'h6dd3_2d43;
    reset          = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_rd      = 1'b0;
    bridge_wr_data = '0;
    start_button   = 1'b0;
    rtc_valid      = 1'b0;
    rtc_epoch      = '0;
    request_ready  = 1'b0;
    rgb565         = '0;
    de             = 1'b0;
    hsync          = 1'b0;
    vsync          = 1'b0;
    drive_levels(4'b0000);
    model_plus     = 1'b0;
    model_slot     = '0;
    video_check_en = 1'b0;
    de_h1          = 1'b0;
    de_h2          = 1'b0;
    hs_h1          = 1'b0;
    vs_h1          = 1'b0;
    rgb_h1         = '0;
    n_checks       = 0;
    n_errors       = 0;
    n_tests        = 0;
    n_tests_failed = 0;
    repeat (3) @(posedge clk_sys_57_12);
    @(negedge clk_sys_57_12);
    reset = 1'b0;
    @(negedge clk_sys_57_12);
    test_reset_state();
    test_interact();
    test_settings();
    test_reset_sequencer();
    test_rtc();
    test_requests();
    test_video();
    $display("tests %0d, tests failed %0d, checks %0d, errors %0d",
             n_tests, n_tests_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
src/core_pkg.sv
src/csr_if.sv
src/bridge_decoder.sv
src/interact_regs.sv
src/reset_sequencer.sv
src/rtc_seconds.sv
src/dataslot_request.sv
src/video_formatter.sv
src/core_top.sv
verif/tb_core_top.sv

// File: Makefile
# Verilator build and run for the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail is taken from the log, not from the exit status
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
